//--- include/dcache_config.svh
//////////////////////////////
// dcache configuration
// address split, beat and array sizes
//////////////////////////////
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

`define DC_ADDR_W     32    // cpu byte address
`define DC_BEAT_W     64    // one memory beat, also cpu data width
`define DC_LINE_BEATS 2     // 16 byte line

`define DC_OFFSET_W   4
`define DC_SETS       16
`define DC_INDEX_W    4
`define DC_TAG_W      24    // addr - index - offset

// associativity
`define DC_WAYS       4

`endif

//--- design/dcache_pkg.sv
//////////////////////////////
// dcache shared types
// beat union, way number, age counter
//////////////////////////////
`include "dcache_config.svh"

package dcache_pkg;

    // one beat seen as a double word or as byte lanes
    typedef union packed {
        logic [`DC_BEAT_W-1:0]                dword;
        logic [`DC_BEAT_W/8-1:0][7:0]         bytes;  // lane 0 = lowest address
    } dc_beat_u;

    typedef logic [1:0] dc_way_t;   // 4 ways

    // saturating 0..3, larger means older
    typedef logic [1:0] dc_age_t;

endpackage

//--- design/dcache_tag_store.sv
//////////////////////////////
// dcache tag store
// tag/valid/dirty/age per set, hit and victim lookup
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tag_store
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`DC_INDEX_W-1:0] index_i,
    input  logic [`DC_TAG_W-1:0] tag_i,
    output logic                 hit_o,
    output dc_way_t              hit_way_o,
    output dc_way_t              victim_way_o,
    output logic [`DC_TAG_W-1:0] victim_tag_o,
    output logic                 victim_dirty_o,
    input  logic                 touch_i,       // age the set around the hit way
    input  logic                 set_dirty_i,
    input  logic                 fill_i,        // install tag_i in victim way
    input  logic                 fill_dirty_i
);

    logic [`DC_TAG_W-1:0]   tag_q   [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0]    valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0]    dirty_q [`DC_SETS];
    dc_age_t [`DC_WAYS-1:0] age_q   [`DC_SETS];

    logic [`DC_WAYS-1:0] hit_vec;

    function automatic dc_age_t age_up(input dc_age_t a);
        return (a == 2'd3) ? a : a + 2'd1;  // saturate at oldest
    endfunction

    // compare all ways of the indexed set
    always_comb begin
        hit_vec   = '0;
        hit_way_o = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid_q[index_i][w] && (tag_q[index_i][w] == tag_i);
            if (hit_vec[w])
                hit_way_o = dc_way_t'(w);
        end
    end
    assign hit_o = |hit_vec;

    // lowest free way first, else oldest, lowest index on a tie
    always_comb begin
        dc_age_t best_age;
        logic    free_found;
        victim_way_o = '0;
        best_age     = age_q[index_i][0];
        free_found   = !valid_q[index_i][0];
        for (int w = 1; w < `DC_WAYS; w++) begin
            if (!free_found && !valid_q[index_i][w]) begin
                victim_way_o = dc_way_t'(w);
                free_found   = 1'b1;
            end else if (!free_found && age_q[index_i][w] > best_age) begin
                victim_way_o = dc_way_t'(w);
                best_age     = age_q[index_i][w];
            end
        end
    end

    assign victim_tag_o   = tag_q[index_i][victim_way_o];
    assign victim_dirty_o = valid_q[index_i][victim_way_o] && dirty_q[index_i][victim_way_o];

    // tag array, written on fill only
    always_ff @(posedge clk) begin
        if (fill_i)
            tag_q[index_i][victim_way_o] <= tag_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            age_q   <= '{default: '0};
        end else if (fill_i) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (dc_way_t'(w) == victim_way_o) begin
                    valid_q[index_i][w] <= 1'b1;
                    dirty_q[index_i][w] <= fill_dirty_i;  // store miss fills dirty
                    age_q[index_i][w]   <= '0;            // newest
                end else begin
                    age_q[index_i][w] <= age_up(age_q[index_i][w]);
                end
            end
        end else begin
            if (touch_i) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    if (dc_way_t'(w) == hit_way_o)
                        age_q[index_i][w] <= (age_q[index_i][w] == '0) ? '0
                                           : age_q[index_i][w] - 2'd1;
                    else
                        age_q[index_i][w] <= age_up(age_q[index_i][w]);
                end
            end
            if (set_dirty_i)
                dirty_q[index_i][hit_way_o] <= 1'b1;  // write hit
        end
    end

    // a line lives in one way only, refill must never duplicate a tag
    a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec))
        else $error("tag store: multiple ways hit in set %0d", index_i);

endmodule

//--- design/dcache_data_store.sv
//////////////////////////////
// dcache data store
// line ram, registered read, byte masked write
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_data_store
    import dcache_pkg::*;
(
    input  logic                          clk,
    input  logic [`DC_INDEX_W-1:0]        index_i,
    input  dc_way_t                       way_i,
    input  logic                          rd_en_i,
    output dc_beat_u [`DC_LINE_BEATS-1:0] rd_line_o,   // valid the cycle after rd_en_i
    input  logic                          wr_en_i,
    input  dc_beat_u [`DC_LINE_BEATS-1:0] wr_line_i,
    input  logic [`DC_LINE_BEATS*`DC_BEAT_W/8-1:0] wr_strb_i  // one bit per line byte
);

    localparam int LANES = `DC_BEAT_W / 8;

    dc_beat_u [`DC_LINE_BEATS-1:0] mem_q [`DC_WAYS][`DC_SETS];

    // read port, output holds until next read
    always_ff @(posedge clk) begin
        if (rd_en_i)
            rd_line_o <= mem_q[way_i][index_i];
    end

    // byte lanes through the union's byte view
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < `DC_LINE_BEATS; b++) begin
                for (int k = 0; k < LANES; k++) begin
                    if (wr_strb_i[b*LANES + k])
                        mem_q[way_i][index_i][b].bytes[k] <= wr_line_i[b].bytes[k];
                end
            end
        end
    end

    // single port, controller must never overlap a lookup with a fill or merge
    a_rd_wr_excl: assert property (@(posedge clk) !(rd_en_i && wr_en_i))
        else $error("data store: read and write in same cycle");

endmodule

//--- design/dcache_ctrl.sv
//////////////////////////////
// dcache controller
// request fsm, store merge, write-back and refill
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // cpu side
    input  logic                   cpu_valid_i,
    input  logic                   cpu_we_i,
    input  logic [`DC_ADDR_W-1:0]  cpu_addr_i,
    input  logic [`DC_BEAT_W-1:0]  cpu_wdata_i,
    input  logic [1:0]             cpu_size_i,     // 1/2/4/8 bytes
    output logic                   cpu_ready_o,
    output logic [`DC_BEAT_W-1:0]  cpu_rdata_o,
    // memory read
    output logic                   mem_rd_req_o,
    output logic [`DC_ADDR_W-1:0]  mem_rd_addr_o,
    input  logic                   mem_rd_valid_i,
    input  logic [`DC_BEAT_W-1:0]  mem_rd_data_i,
    input  logic                   mem_rd_last_i,
    // memory write
    output logic                   mem_wr_valid_o,
    output logic [`DC_ADDR_W-1:0]  mem_wr_addr_o,
    output logic [`DC_BEAT_W-1:0]  mem_wr_data_o,
    input  logic                   mem_wr_ready_i,
    input  logic                   mem_wr_last_i,
    // both stores
    output logic [`DC_INDEX_W-1:0] index_o,
    output logic [`DC_TAG_W-1:0]   tag_o,
    output dc_way_t                way_o,
    output logic                   rd_en_o,
    input  dc_beat_u [`DC_LINE_BEATS-1:0] rd_line_i,
    output logic                   wr_en_o,
    output dc_beat_u [`DC_LINE_BEATS-1:0] wr_line_o,
    output logic [`DC_LINE_BEATS*`DC_BEAT_W/8-1:0] wr_strb_o,
    input  logic                   hit_i,
    input  dc_way_t                hit_way_i,
    input  dc_way_t                victim_way_i,
    input  logic [`DC_TAG_W-1:0]   victim_tag_i,
    input  logic                   victim_dirty_i,
    output logic                   touch_o,
    output logic                   set_dirty_o,
    output logic                   fill_o,
    output logic                   fill_dirty_o
);

    typedef enum logic [2:0] {IDLE, LOOKUP, WBACK, REFILL, STORE, RESP} state_t;

    state_t state_q, state_d;

    logic [`DC_ADDR_W-1:0] addr_q;      // held request
    logic                  we_q;
    logic [`DC_BEAT_W-1:0] wdata_q;
    logic [1:0]            size_q;
    logic                  miss_q;      // answer from refill buffer
    logic                  wb_beat_q;   // beat being written back
    dc_beat_u [`DC_LINE_BEATS-1:0] line_q;  // refill beats

    logic [7:0]            size_mask;
    logic [7:0]            strb8;
    logic [`DC_BEAT_W-1:0] wdata_sh;
    logic                  rd_last;
    dc_beat_u [`DC_LINE_BEATS-1:0] resp_line;
    dc_beat_u              resp_beat;

    assign index_o = addr_q[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag_o   = addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign rd_last = (state_q == REFILL) && mem_rd_valid_i && mem_rd_last_i;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (cpu_valid_i) state_d = LOOKUP;
            LOOKUP:  state_d = hit_i ? RESP : (victim_dirty_i ? WBACK : REFILL);
            WBACK:   if (mem_wr_ready_i && mem_wr_last_i) state_d = REFILL;
            REFILL:  if (rd_last) state_d = we_q ? STORE : RESP;
            STORE:   state_d = RESP;    // merge into fresh line
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            miss_q    <= 1'b0;
            wb_beat_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP)
                miss_q <= !hit_i;
            if (state_q == WBACK && mem_wr_ready_i)
                wb_beat_q <= !wb_beat_q;    // back to 0 after last beat
        end
    end

    // request and refill payload
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cpu_valid_i) begin
            addr_q  <= cpu_addr_i;
            we_q    <= cpu_we_i;
            wdata_q <= cpu_wdata_i;
            size_q  <= cpu_size_i;
        end
        if (state_q == REFILL && mem_rd_valid_i) begin
            if (mem_rd_last_i)
                line_q[1].dword <= mem_rd_data_i;
            else
                line_q[0].dword <= mem_rd_data_i;  // low beat first
        end
    end

    // store strobe and data placed at the byte offset
    always_comb begin
        case (size_q)
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end
    assign strb8    = size_mask << addr_q[2:0];
    assign wdata_sh = wdata_q << {addr_q[2:0], 3'b000};

    // hit way on a hit and the victim way otherwise
    assign way_o        = hit_i ? hit_way_i : victim_way_i;
    assign rd_en_o      = (state_q == LOOKUP) && !(hit_i && we_q);
    assign wr_en_o      = ((state_q == LOOKUP) && hit_i && we_q) || rd_last
                          || (state_q == STORE);
    assign wr_line_o    = (state_q == REFILL) ? {mem_rd_data_i, line_q[0].dword}
                                              : {wdata_sh, wdata_sh};
    assign wr_strb_o    = (state_q == REFILL) ? '1
                        : (addr_q[3] ? {strb8, 8'h00} : {8'h00, strb8});
    assign touch_o      = (state_q == LOOKUP) && hit_i;
    assign set_dirty_o  = touch_o && we_q;
    assign fill_o       = rd_last;
    assign fill_dirty_o = we_q;

    // memory side levels follow the state
    assign mem_rd_req_o   = (state_q == REFILL);
    assign mem_rd_addr_o  = {addr_q[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign mem_wr_valid_o = (state_q == WBACK);
    assign mem_wr_addr_o  = {victim_tag_i, index_o, {`DC_OFFSET_W{1'b0}}};
    assign mem_wr_data_o  = rd_line_i[wb_beat_q].dword;  // victim read in LOOKUP

    // cpu response
    assign resp_line   = miss_q ? line_q : rd_line_i;
    assign resp_beat   = resp_line[addr_q[3]];
    assign cpu_rdata_o = resp_beat.dword >> {addr_q[2:0], 3'b000};
    assign cpu_ready_o = (state_q == RESP);

    // cpu must hold valid until the ready pulse
    a_ready_valid: assert property (@(posedge clk) disable iff (rst)
        cpu_ready_o |-> cpu_valid_i)
        else $error("ctrl: ready without a held request");

    // a stalled write-back beat holds until memory takes it
    a_wr_hold: assert property (@(posedge clk) disable iff (rst)
        mem_wr_valid_o && !mem_wr_ready_i |=> mem_wr_valid_o
            && $stable(mem_wr_addr_o) && $stable(mem_wr_data_o))
        else $error("ctrl: write-back beat changed while stalled");

endmodule

//--- design/dcache_top.sv
//////////////////////////////
// dcache top
// controller beside tag and data stores
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_valid_i,
    input  logic                  cpu_we_i,
    input  logic [`DC_ADDR_W-1:0] cpu_addr_i,
    input  logic [`DC_BEAT_W-1:0] cpu_wdata_i,
    input  logic [1:0]            cpu_size_i,
    output logic                  cpu_ready_o,
    output logic [`DC_BEAT_W-1:0] cpu_rdata_o,
    output logic                  mem_rd_req_o,
    output logic [`DC_ADDR_W-1:0] mem_rd_addr_o,
    input  logic                  mem_rd_valid_i,
    input  logic [`DC_BEAT_W-1:0] mem_rd_data_i,
    input  logic                  mem_rd_last_i,
    output logic                  mem_wr_valid_o,
    output logic [`DC_ADDR_W-1:0] mem_wr_addr_o,
    output logic [`DC_BEAT_W-1:0] mem_wr_data_o,
    input  logic                  mem_wr_ready_i,
    input  logic                  mem_wr_last_i
);

    logic [`DC_INDEX_W-1:0]        index;
    logic [`DC_TAG_W-1:0]          tag;
    dc_way_t                       way;
    logic                          rd_en;
    dc_beat_u [`DC_LINE_BEATS-1:0] rd_line;
    logic                          wr_en;
    dc_beat_u [`DC_LINE_BEATS-1:0] wr_line;
    logic [`DC_LINE_BEATS*`DC_BEAT_W/8-1:0] wr_strb;
    logic                          hit;
    dc_way_t                       hit_way;
    dc_way_t                       victim_way;
    logic [`DC_TAG_W-1:0]          victim_tag;
    logic                          victim_dirty;
    logic                          touch;
    logic                          set_dirty;
    logic                          fill;
    logic                          fill_dirty;

    dcache_ctrl i_dcache_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_valid_i    (cpu_valid_i),
        .cpu_we_i       (cpu_we_i),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_wdata_i    (cpu_wdata_i),
        .cpu_size_i     (cpu_size_i),
        .cpu_ready_o    (cpu_ready_o),
        .cpu_rdata_o    (cpu_rdata_o),
        .mem_rd_req_o   (mem_rd_req_o),
        .mem_rd_addr_o  (mem_rd_addr_o),
        .mem_rd_valid_i (mem_rd_valid_i),
        .mem_rd_data_i  (mem_rd_data_i),
        .mem_rd_last_i  (mem_rd_last_i),
        .mem_wr_valid_o (mem_wr_valid_o),
        .mem_wr_addr_o  (mem_wr_addr_o),
        .mem_wr_data_o  (mem_wr_data_o),
        .mem_wr_ready_i (mem_wr_ready_i),
        .mem_wr_last_i  (mem_wr_last_i),
        .index_o        (index),
        .tag_o          (tag),
        .way_o          (way),
        .rd_en_o        (rd_en),
        .rd_line_i      (rd_line),
        .wr_en_o        (wr_en),
        .wr_line_o      (wr_line),
        .wr_strb_o      (wr_strb),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_tag_i   (victim_tag),
        .victim_dirty_i (victim_dirty),
        .touch_o        (touch),
        .set_dirty_o    (set_dirty),
        .fill_o         (fill),
        .fill_dirty_o   (fill_dirty)
    );

    dcache_tag_store i_dcache_tag_store (
        .clk            (clk),
        .rst            (rst),
        .index_i        (index),
        .tag_i          (tag),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_tag_o   (victim_tag),
        .victim_dirty_o (victim_dirty),
        .touch_i        (touch),
        .set_dirty_i    (set_dirty),
        .fill_i         (fill),
        .fill_dirty_i   (fill_dirty)
    );

    dcache_data_store i_dcache_data_store (
        .clk       (clk),
        .index_i   (index),
        .way_i     (way),
        .rd_en_i   (rd_en),
        .rd_line_o (rd_line),
        .wr_en_i   (wr_en),
        .wr_line_i (wr_line),
        .wr_strb_i (wr_strb)
    );

endmodule

//--- bench/dcache_tb.sv
//////////////////////////////
// dcache testbench
// random cpu traffic against a reference cache and memory model
//////////////////////////////
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb;

    localparam int NT      = 6;     // more tags per set than ways
    localparam int NS      = 3;     // sets in use
    localparam int NUM_OPS = 400;
    localparam int MAX_CYC = 200;   // per access
    localparam logic [`DC_TAG_W-1:0] TAG_BASE = 24'h91c3a0;

    logic                  clk;
    logic                  rst;
    logic                  cpu_valid_i;
    logic                  cpu_we_i;
    logic [`DC_ADDR_W-1:0] cpu_addr_i;
    logic [`DC_BEAT_W-1:0] cpu_wdata_i;
    logic [1:0]            cpu_size_i;
    logic                  cpu_ready_o;
    logic [`DC_BEAT_W-1:0] cpu_rdata_o;
    logic                  mem_rd_req_o;
    logic [`DC_ADDR_W-1:0] mem_rd_addr_o;
    logic                  mem_rd_valid_i;
    logic [`DC_BEAT_W-1:0] mem_rd_data_i;
    logic                  mem_rd_last_i;
    logic                  mem_wr_valid_o;
    logic [`DC_ADDR_W-1:0] mem_wr_addr_o;
    logic [`DC_BEAT_W-1:0] mem_wr_data_o;
    logic                  mem_wr_ready_i;
    logic                  mem_wr_last_i;

    logic [3:0]  set_tab [NS] = '{4'd2, 4'd9, 4'd15};
    logic [63:0] mem_img [NT][NS][2];   // what memory holds
    logic [63:0] cpu_img [NT][NS][2];   // what the cpu last wrote
    logic        seen    [NT][NS];      // line touched before
    int          m_tag   [NS][`DC_WAYS];
    logic        m_val   [NS][`DC_WAYS];
    logic        m_dirty [NS][`DC_WAYS];
    int          m_age   [NS][`DC_WAYS];
    int          chk_cnt [6];
    int          err_cnt [6];
    string       test_name [6] = '{"read data", "store merge", "hit traffic",
                                   "replacement", "write-back data", "reset state"};
    logic        timed_out;

    dcache_top i_dcache_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [`DC_ADDR_W-1:0] line_addr(input int t, input int si);
        return {TAG_BASE + `DC_TAG_W'(t), set_tab[si], 4'h0};
    endfunction

    function automatic int age_inc(input int a);
        return (a == 3) ? 3 : a + 1;
    endfunction

    task automatic check_val(input int id, input string name,
                             input logic [63:0] got, input logic [63:0] exp);
        chk_cnt[id]++;
        if (got !== exp) begin
            err_cnt[id]++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one cpu request with the memory side answered cycle by cycle
    task automatic do_access(input logic we, input int t, input int si, input logic [3:0] off,
                             input logic [1:0] size, input logic [63:0] wdata, input int id);
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_ADDR_W-1:0] held_addr;
        logic [63:0]           held_data;
        logic [63:0]           rdata;
        logic                  hit;
        logic                  exp_wb;
        logic                  done;
        logic                  saw_rd;
        logic                  saw_wr;
        logic                  hold;
        logic                  nxt_rv;
        logic                  nxt_ready;
        int                    hw;
        int                    vw;
        int                    vt;
        int                    rd_beats;
        int                    wr_beats;
        int                    o;
        addr = line_addr(t, si) | 32'(off);
        hit  = 1'b0;
        hw   = 0;
        vw   = -1;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (m_val[si][w] && m_tag[si][w] == t) begin
                hit = 1'b1;
                hw  = w;
            end
            if (vw < 0 && !m_val[si][w])
                vw = w;     // lowest free way
        end
        if (vw < 0) begin
            vw = 0;
            for (int w = 1; w < `DC_WAYS; w++) begin
                if (m_age[si][w] > m_age[si][vw])
                    vw = w;     // oldest way wins and ties keep the lowest
            end
        end
        vt     = m_tag[si][vw];
        exp_wb = !hit && m_val[si][vw] && m_dirty[si][vw];

        @(posedge clk);
        cpu_valid_i <= 1'b1;
        cpu_we_i    <= we;
        cpu_addr_i  <= addr;
        cpu_wdata_i <= wdata;
        cpu_size_i  <= size;
        done     = 1'b0;
        saw_rd   = 1'b0;
        saw_wr   = 1'b0;
        hold     = 1'b0;
        rd_beats = 0;
        wr_beats = 0;
        for (int cyc = 0; cyc < MAX_CYC && !done; cyc++) begin
            @(negedge clk);     // outputs settled here
            if (mem_rd_valid_i)
                rd_beats++;     // taken at the coming edge
            if (mem_rd_req_o && !saw_rd) begin
                saw_rd = 1'b1;
                check_val(3, "mem_rd_addr_o", 64'(mem_rd_addr_o), 64'(line_addr(t, si)));
            end
            if (hold) begin     // stalled beat must not move
                check_val(4, "mem_wr_valid_o", 64'(mem_wr_valid_o), 64'd1);
                check_val(4, "mem_wr_addr_o", 64'(mem_wr_addr_o), 64'(held_addr));
                check_val(4, "mem_wr_data_o", mem_wr_data_o, held_data);
            end
            if (mem_wr_valid_o) begin
                saw_wr = 1'b1;
                if (mem_wr_ready_i && exp_wb && wr_beats < 2) begin
                    check_val(3, "mem_wr_addr_o", 64'(mem_wr_addr_o), 64'(line_addr(vt, si)));
                    check_val(4, "mem_wr_data_o", mem_wr_data_o, cpu_img[vt][si][wr_beats]);
                    mem_img[vt][si][wr_beats] = mem_wr_data_o;
                    wr_beats++;
                end
            end
            hold      = mem_wr_valid_o && !mem_wr_ready_i;
            held_addr = mem_wr_addr_o;
            held_data = mem_wr_data_o;
            done      = cpu_ready_o;
            rdata     = cpu_rdata_o;
            nxt_rv    = mem_rd_req_o && rd_beats < 2 && ($urandom % 3 != 0);
            nxt_ready = ($urandom % 3 != 0);
            @(posedge clk);
            mem_rd_valid_i <= nxt_rv;
            mem_rd_data_i  <= mem_img[t][si][rd_beats % 2];
            mem_rd_last_i  <= (rd_beats == 1);  // second beat
            mem_wr_ready_i <= nxt_ready;
            mem_wr_last_i  <= (wr_beats == 1);
            if (done)
                cpu_valid_i <= 1'b0;
        end
        if (!done) begin
            $display("timeout: access to %h got no cpu_ready_o in %0d cycles", addr, MAX_CYC);
            err_cnt[id]++;
            timed_out = 1'b1;
            return;
        end

        if (hit) begin
            check_val(2, "mem_rd_req_o", 64'(saw_rd), 64'd0);
            check_val(2, "mem_wr_valid_o", 64'(saw_wr), 64'd0);
        end else begin
            check_val(3, "mem_rd_req_o", 64'(saw_rd), 64'd1);
            check_val(3, "mem_wr_valid_o", 64'(saw_wr), 64'(exp_wb));
        end
        if (!seen[t][si])
            check_val(5, "mem_rd_req_o", 64'(saw_rd), 64'd1);   // cold line misses
        seen[t][si] = 1'b1;
        if (!we)
            check_val(id, "cpu_rdata_o", rdata, cpu_img[t][si][off[3]] >> (8 * off[2:0]));

        // reference tag state
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (hit && w == hw) begin
                m_age[si][w] = (m_age[si][w] == 0) ? 0 : m_age[si][w] - 1;
                if (we)
                    m_dirty[si][w] = 1'b1;
            end else if (!hit && w == vw) begin
                m_tag[si][w]   = t;
                m_val[si][w]   = 1'b1;
                m_dirty[si][w] = we;    // store miss fills dirty
                m_age[si][w]   = 0;
            end else begin
                m_age[si][w] = age_inc(m_age[si][w]);
            end
        end
        if (we) begin
            for (int k = 0; k < (1 << size); k++) begin
                o = int'(off[2:0]) + k;
                cpu_img[t][si][off[3]][8*o +: 8] = wdata[8*k +: 8];
            end
        end
    endtask

    initial begin
        int          r;
        int          t;
        int          si;
        int          tot_chk;
        int          tot_err;
        logic [3:0]  off;
        logic [1:0]  size;
        logic        we;
        r = $urandom(32'h32cb_9fd3);
        rst            = 1'b1;
        cpu_valid_i    = 1'b0;
        cpu_we_i       = 1'b0;
        cpu_addr_i     = '0;
        cpu_wdata_i    = '0;
        cpu_size_i     = 2'd0;
        mem_rd_valid_i = 1'b0;
        mem_rd_data_i  = '0;
        mem_rd_last_i  = 1'b0;
        mem_wr_ready_i = 1'b0;
        mem_wr_last_i  = 1'b0;
        timed_out      = 1'b0;
        for (int i = 0; i < 6; i++) begin
            chk_cnt[i] = 0;
            err_cnt[i] = 0;
        end
        for (int s = 0; s < NS; s++) begin
            for (int a = 0; a < NT; a++) begin
                seen[a][s] = 1'b0;
                for (int b = 0; b < 2; b++) begin
                    mem_img[a][s][b] = {$urandom, $urandom};
                    cpu_img[a][s][b] = mem_img[a][s][b];
                end
            end
            for (int w = 0; w < `DC_WAYS; w++) begin
                m_tag[s][w]   = 0;
                m_val[s][w]   = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = 0;
            end
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val(5, "cpu_ready_o", 64'(cpu_ready_o), 64'd0);
        check_val(5, "mem_rd_req_o", 64'(mem_rd_req_o), 64'd0);
        check_val(5, "mem_wr_valid_o", 64'(mem_wr_valid_o), 64'd0);

        for (int n = 0; n < NUM_OPS && !timed_out; n++) begin
            t    = $urandom % NT;
            si   = $urandom % NS;
            size = 2'($urandom % 4);
            off  = 4'($urandom % 16) & ~4'((1 << size) - 1);   // natural alignment
            we   = 1'($urandom % 2);
            do_access(we, t, si, off, size, {$urandom, $urandom}, 0);
            if (we && !timed_out && ($urandom % 2 == 0))
                do_access(1'b0, t, si, {off[3], 3'b000}, 2'd3, 64'd0, 1);  // read back dword
        end

        tot_chk = 0;
        tot_err = 0;
        for (int i = 0; i < 6; i++) begin
            $display("test %0d %s: %0d checks, %0d errors", i + 1, test_name[i],
                     chk_cnt[i], err_cnt[i]);
            tot_chk += chk_cnt[i];
            tot_err += err_cnt[i];
        end
        $display("total: %0d checks, %0d errors", tot_chk, tot_err);
        if (tot_err == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
design/dcache_pkg.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_ctrl.sv
design/dcache_top.sv
bench/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dcache_tb -f verilog.f -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    exit 0
fi
exit 1
